// ==== design/div_cfg_pkg.sv ====
// Divider sizes: operand width, digit count, stage limit and counter width
package div_cfg_pkg;

    // Operand width of dividend, divisor, quotient and remainder
    localparam int DATA_WIDTH = 32;

    // Two quotient bits per radix-4 digit
    localparam int RADIX4_DIGITS = DATA_WIDTH / 2;

    // Longest digit chain allowed in one clock
    localparam int MAX_DIGITS_PER_CYCLE = 8;

    // Iteration counter, enough for one digit per cycle
    localparam int COUNT_WIDTH = 5;

endpackage

// ==== design/div_control.sv ====
// Divider control: handshake FSM, iteration counter and datapath strobes
`timescale 1ns/100ps

module div_control #(
    parameter int DIGITS_PER_CYCLE = 2
) (
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic done,
    output logic load,
    output logic step,
    output logic capture
);

    localparam int CW = div_cfg_pkg::COUNT_WIDTH;
    localparam int STEPS = div_cfg_pkg::RADIX4_DIGITS / DIGITS_PER_CYCLE;
    localparam logic [CW-1:0] LAST_STEP = CW'(STEPS - 1);

    div_types_pkg::ctl_state_t state;
    logic [CW-1:0]             count;
    logic                      accept;

    if ((DIGITS_PER_CYCLE < 1) ||
        (DIGITS_PER_CYCLE > div_cfg_pkg::MAX_DIGITS_PER_CYCLE) ||
        (div_cfg_pkg::RADIX4_DIGITS % DIGITS_PER_CYCLE != 0)) begin : g_param_check
        $error("DIGITS_PER_CYCLE must divide %0d and not exceed %0d",
               div_cfg_pkg::RADIX4_DIGITS, div_cfg_pkg::MAX_DIGITS_PER_CYCLE);
    end

    assign accept = trigger && ready;

    // Operands are taken on the accepting edge itself
    assign load = accept;

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state   <= div_types_pkg::ST_IDLE;
            count   <= '0;
            ready   <= 1'b0;
            step    <= 1'b0;
            capture <= 1'b0;
            done    <= 1'b0;
        end else begin
            done    <= capture;
            capture <= 1'b0;
            case (state)
                div_types_pkg::ST_IDLE,
                div_types_pkg::ST_DONE: begin
                    ready <= 1'b1;
                    if (accept) begin
                        state <= div_types_pkg::ST_CALC;
                        ready <= 1'b0;
                        step  <= 1'b1;
                        count <= '0;
                    end else begin
                        state <= div_types_pkg::ST_IDLE;
                    end
                end
                div_types_pkg::ST_CALC: begin
                    if (capture) begin
                        // Result lands together with done
                        state <= div_types_pkg::ST_DONE;
                        ready <= 1'b1;
                    end else if (count == LAST_STEP) begin
                        step    <= 1'b0;
                        capture <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= div_types_pkg::ST_IDLE;
                    step  <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== design/div_datapath.sv ====
// Divider datapath: operand and working registers, multiples, stage chain, results
`timescale 1ns/100ps

module div_datapath #(
    parameter int DIGITS_PER_CYCLE = 2
) (
    input  logic                 ctl_clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 step,
    input  logic                 capture,
    input  div_types_pkg::word_t a,
    input  div_types_pkg::word_t b,
    output div_types_pkg::word_t q,
    output div_types_pkg::word_t r
);

    localparam int DW = div_cfg_pkg::DATA_WIDTH;
    localparam int SHIFT = 2 * DIGITS_PER_CYCLE;

    div_types_pkg::word_t                          divisor;
    div_types_pkg::calc_word_t                     work;
    div_types_pkg::word_t [DIGITS_PER_CYCLE:0]     stage_rem;
    logic [SHIFT-1:0]                              step_digits;

    divisor_mult_if mult_bus ();

    // Multiples stay fixed for the whole operation
    assign mult_bus.x1      = divisor;
    assign mult_bus.x2      = {1'b0, divisor, 1'b0};
    assign mult_bus.x3      = mult_bus.x2 + {2'b00, divisor};
    assign mult_bus.x2_fits = (mult_bus.x2[DW+1:DW] == 2'b00);
    assign mult_bus.x3_fits = (mult_bus.x3[DW+1:DW] == 2'b00);

    assign stage_rem[0] = work.shift[2*DW-1:DW];

    // Stage 0 takes the top dividend bits and yields the most significant digit
    for (genvar i = 0; i < DIGITS_PER_CYCLE; i++) begin : g_stage
        radix4_digit_stage u_stage (
            .rem_in    (stage_rem[i]),
            .next_bits (work.shift[DW-1-2*i -: 2]),
            .mult      (mult_bus),
            .rem_out   (stage_rem[i+1]),
            .digit     (step_digits[SHIFT-1-2*i -: 2])
        );
    end

    always_ff @(posedge ctl_clk) begin
        if (load) begin
            divisor         <= b;
            work.parts.rem  <= '0;
            work.parts.quo  <= a;
        end else if (step) begin
            work.shift <= {stage_rem[DIGITS_PER_CYCLE], work.shift[DW-SHIFT-1:0], step_digits};
        end
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            q <= '0;
            r <= '0;
        end else if (capture) begin
            q <= work.parts.quo;
            r <= work.parts.rem;
        end
    end

endmodule

// ==== design/div_types_pkg.sv ====
// Divider data types: words, digits, working register union, control states
package div_types_pkg;

    // Operand, quotient or remainder
    typedef logic [div_cfg_pkg::DATA_WIDTH-1:0] word_t;

    // Divisor multiple, up to three times the divisor
    typedef logic [div_cfg_pkg::DATA_WIDTH+1:0] wide_word_t;

    // One radix-4 quotient digit
    typedef logic [1:0] digit_t;

    // Working register
    // shifted as one word while dividing, split into remainder and quotient at the end
    typedef union packed {
        logic [2*div_cfg_pkg::DATA_WIDTH-1:0] shift;
        struct packed {
            word_t rem;
            word_t quo;
        } parts;
    } calc_word_t;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } ctl_state_t;

endpackage

// ==== design/divisor_mult_if.sv ====
// Interface with the divisor multiples and their fit flags for the digit stages
`timescale 1ns/100ps

interface divisor_mult_if;

    // One, two and three times the divisor
    div_types_pkg::word_t      x1;
    div_types_pkg::wide_word_t x2;
    div_types_pkg::wide_word_t x3;

    // Multiple has nothing above the operand width
    logic x2_fits;
    logic x3_fits;

    modport source (
        output x1, x2, x3, x2_fits, x3_fits
    );

    modport stage (
        input x1, x2, x3, x2_fits, x3_fits
    );

endinterface

// ==== design/radix4_digit_stage.sv ====
// Radix-4 digit stage: three trial subtractions and priority digit select
`timescale 1ns/100ps

module radix4_digit_stage (
    input  div_types_pkg::word_t  rem_in,
    input  div_types_pkg::digit_t next_bits,
    divisor_mult_if.stage         mult,
    output div_types_pkg::word_t  rem_out,
    output div_types_pkg::digit_t digit
);

    localparam int DW = div_cfg_pkg::DATA_WIDTH;

    div_types_pkg::wide_word_t shifted;
    logic [DW:0]               diff1;
    logic [DW:0]               diff2;
    logic [DW:0]               diff3;
    logic                      ge1;
    logic                      ge2;
    logic                      ge3;

    // Shifted value covers the multiple, from the top bits and the low word borrow
    function automatic logic covers(input logic [1:0] top, input logic [1:0] mult_top,
                                    input logic fits, input logic borrow);
        logic ge;
        if (fits) begin
            ge = (top != 2'b00) || !borrow;
        end else begin
            ge = (top > mult_top) || ((top == mult_top) && !borrow);
        end
        return ge;
    endfunction

    assign shifted = {rem_in, next_bits};

    // Low word differences, top bit is the borrow
    assign diff1 = {1'b0, shifted[DW-1:0]} - {1'b0, mult.x1};
    assign diff2 = {1'b0, shifted[DW-1:0]} - {1'b0, mult.x2[DW-1:0]};
    assign diff3 = {1'b0, shifted[DW-1:0]} - {1'b0, mult.x3[DW-1:0]};

    assign ge1 = covers(shifted[DW+1:DW], 2'b00, 1'b1, diff1[DW]);
    assign ge2 = covers(shifted[DW+1:DW], mult.x2[DW+1:DW], mult.x2_fits, diff2[DW]);
    assign ge3 = covers(shifted[DW+1:DW], mult.x3[DW+1:DW], mult.x3_fits, diff3[DW]);

    // Highest multiple that fits wins, the new remainder is below the divisor
    always_comb begin
        if (ge3) begin
            digit   = 2'd3;
            rem_out = diff3[DW-1:0];
        end else if (ge2) begin
            digit   = 2'd2;
            rem_out = diff2[DW-1:0];
        end else if (ge1) begin
            digit   = 2'd1;
            rem_out = diff1[DW-1:0];
        end else begin
            digit   = 2'd0;
            rem_out = shifted[DW-1:0];
        end
    end

endmodule

// ==== design/radix4_divider.sv ====
// Radix-4 iterative divider top level: control FSM and datapath
`timescale 1ns/100ps

module radix4_divider #(
    parameter int DIGITS_PER_CYCLE = 2
) (
    input  logic                 ctl_clk,
    input  logic                 reset,
    input  logic                 trigger,
    input  div_types_pkg::word_t a,
    input  div_types_pkg::word_t b,
    output logic                 ready,
    output logic                 done,
    output div_types_pkg::word_t q,
    output div_types_pkg::word_t r
);

    logic load;
    logic step;
    logic capture;

    div_control #(
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) u_control (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .load    (load),
        .step    (step),
        .capture (capture)
    );

    div_datapath #(
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) u_datapath (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .load    (load),
        .step    (step),
        .capture (capture),
        .a       (a),
        .b       (b),
        .q       (q),
        .r       (r)
    );

endmodule

// ==== radix4_divider.f ====
design/div_cfg_pkg.sv
design/div_types_pkg.sv
design/divisor_mult_if.sv
design/div_control.sv
design/radix4_digit_stage.sv
design/div_datapath.sv
design/radix4_divider.sv
test/radix4_divider_sva.sv
test/radix4_divider_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the radix-4 divider testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=radix4_divider_sim

verilator --binary --timing --assert -j 0 \
    --top-module radix4_divider_tb \
    -f radix4_divider.f \
    --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$build_dir/$sim_bin")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$output"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== test/radix4_divider_sva.sv ====
// Divider handshake and latency assertions, bound to the top level
`timescale 1ns/100ps

module radix4_divider_sva #(
    parameter int DIGITS_PER_CYCLE = 2
) (
    input logic ctl_clk,
    input logic reset,
    input logic trigger,
    input logic ready,
    input logic done
);

    localparam int N = div_cfg_pkg::RADIX4_DIGITS / DIGITS_PER_CYCLE;

    logic busy;
    int   since;

    // Edges since the accepting edge of the division in flight
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            busy  <= 1'b0;
            since <= 0;
        end else if (trigger && ready) begin
            busy  <= 1'b1;
            since <= 0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            since <= since + 1;
        end
    end

    done_one_cycle: assert property (@(posedge ctl_clk) disable iff (!reset)
        done |=> !done)
        else $error("done held high for more than one cycle");

    ready_low_in_flight: assert property (@(posedge ctl_clk) disable iff (!reset)
        (busy && since <= N) |-> !ready)
        else $error("ready high while a division is in flight");

    done_latency: assert property (@(posedge ctl_clk) disable iff (!reset)
        busy |-> (since <= N + 1) && (done == (since == N + 1)))
        else $error("done not exactly %0d cycles after acceptance", N + 1);

endmodule

// ==== test/radix4_divider_tb.sv ====
// Divider testbench: clock, reset, LFSR, compare tasks and directed tests
`timescale 1ns/100ps

module radix4_divider_tb;

    localparam int DIGITS_PER_CYCLE = 2;
    localparam int N = div_cfg_pkg::RADIX4_DIGITS / DIGITS_PER_CYCLE;
    localparam int NUM_OPS = 62;
    localparam int CYCLE_LIMIT = NUM_OPS * (N + 4) + 100;

    logic                 ctl_clk;
    logic                 reset;
    logic                 trigger;
    logic                 ready;
    logic                 done;
    div_types_pkg::word_t a;
    div_types_pkg::word_t b;
    div_types_pkg::word_t q;
    div_types_pkg::word_t r;
    int                   value_errors = 0;
    int                   other_errors = 0;
    int                   cycle_count = 0;
    logic [31:0]          lfsr_state = 32'd83205;

    radix4_divider #(.DIGITS_PER_CYCLE(DIGITS_PER_CYCLE)) radix4_divider_i (.*);

    bind radix4_divider radix4_divider_sva #(
        .DIGITS_PER_CYCLE (DIGITS_PER_CYCLE)
    ) radix4_divider_sva_i (.*);

    initial ctl_clk = 1'b0;
    always #50 ctl_clk = ~ctl_clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int width, output div_types_pkg::word_t value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input div_types_pkg::word_t expected,
                              input div_types_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // Unsigned division, all ones and the dividend for a zero divisor
    task automatic check_result(input div_types_pkg::word_t op_a, input div_types_pkg::word_t op_b);
        div_types_pkg::word_t exp_q;
        div_types_pkg::word_t exp_r;
        exp_q = (op_b == '0) ? '1 : op_a / op_b;
        exp_r = (op_b == '0) ? op_a : op_a % op_b;
        check_word("q", exp_q, q);
        check_word("r", exp_r, r);
    endtask

    task automatic start_division(input div_types_pkg::word_t op_a,
                                  input div_types_pkg::word_t op_b);
        @(posedge ctl_clk);
        trigger <= 1'b1;
        a       <= op_a;
        b       <= op_b;
        @(negedge ctl_clk);
        check_bit("ready", 1'b1, ready);
        @(posedge ctl_clk);
        trigger <= 1'b0;
    endtask

    // Called on the edge numbered elapsed after acceptance
    task automatic wait_done(input int elapsed);
        int cycles;
        cycles = elapsed;
        do begin
            @(posedge ctl_clk);
            cycles++;
            @(negedge ctl_clk);
        end while (!done && cycles < N + 4);
        if (!done) begin
            $display("done did not arrive within %0d cycles of acceptance", cycles);
            other_errors++;
        end else if (cycles != N + 1) begin
            $display("done came %0d cycles after acceptance instead of %0d", cycles, N + 1);
            other_errors++;
        end
    endtask

    task automatic run_division(input div_types_pkg::word_t op_a, input div_types_pkg::word_t op_b);
        start_division(op_a, op_b);
        wait_done(0);
        check_result(op_a, op_b);
    endtask

    task automatic test_reset_state();
        repeat (15) @(posedge ctl_clk);
        @(negedge ctl_clk);
        check_bit("ready", 1'b0, ready);
        @(posedge ctl_clk);
        reset <= 1'b1;
        @(posedge ctl_clk);
        @(negedge ctl_clk);
        check_bit("ready", 1'b1, ready);
        check_bit("done", 1'b0, done);
        check_word("q", '0, q);
        check_word("r", '0, r);
    endtask

    task automatic test_directed();
        run_division(32'd100, 32'd7);
        run_division(32'hdead_beef, 32'd1);
        run_division(32'd5, 32'd1000);
        run_division(32'hffff_ffff, 32'd3);
        run_division(32'd12345, 32'd12345);
        // Three times the divisor overflows the word
        run_division(32'hffff_ffff, 32'h8000_0001);
        run_division(32'hc000_0000, 32'h5555_5556);
    endtask

    task automatic test_random();
        div_types_pkg::word_t op_a;
        div_types_pkg::word_t op_b;
        div_types_pkg::word_t shift;
        repeat (50) begin
            random_bits(32, op_a);
            random_bits(32, op_b);
            random_bits(5, shift);
            // Narrower divisors give longer quotients
            op_b = op_b >> shift;
            if (op_b == '0) begin
                op_b = 32'd1;
            end
            run_division(op_a, op_b);
        end
    endtask

    task automatic test_ignored_trigger();
        start_division(32'd1000, 32'd9);
        repeat (2) @(posedge ctl_clk);
        trigger <= 1'b1;
        a       <= 32'd77;
        b       <= 32'd5;
        @(negedge ctl_clk);
        check_bit("ready", 1'b0, ready);
        repeat (2) @(posedge ctl_clk);
        trigger <= 1'b0;
        wait_done(4);
        check_result(32'd1000, 32'd9);
        // Nothing queued behind the ignored trigger
        repeat (3) begin
            @(negedge ctl_clk);
            check_bit("done", 1'b0, done);
            check_bit("ready", 1'b1, ready);
        end
    endtask

    task automatic test_back_to_back();
        start_division(32'd4096, 32'd10);
        repeat (N + 1) @(posedge ctl_clk);
        trigger <= 1'b1;
        a       <= 32'hffff_0000;
        b       <= 32'd255;
        @(negedge ctl_clk);
        check_bit("done", 1'b1, done);
        check_bit("ready", 1'b1, ready);
        check_result(32'd4096, 32'd10);
        @(posedge ctl_clk);
        trigger <= 1'b0;
        wait_done(0);
        check_result(32'hffff_0000, 32'd255);
    endtask

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge ctl_clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset   <= 1'b0;
        trigger <= 1'b0;
        a       <= '0;
        b       <= '0;
        test_reset_state();
        test_directed();
        test_random();
        run_division(32'h1234_5678, '0);
        run_division('0, '0);
        test_ignored_trigger();
        test_back_to_back();
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
